// File: tb.f
logic/axis_axi_wr_pkg.sv
logic/burst_cmd_if.sv
logic/axi_reg_slice.sv
logic/aw_burst_planner.sv
logic/w_beat_packer.sv
logic/wr_resp_tracker.sv
logic/axis_axi_wr_top.sv
test/tb_axi_wr_checker.sv
test/tb_axis_axi_wr.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_axis_axi_wr -f tb.f -o tb_sim \
   && { ./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log; } \
   || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

// File: test/tb_axis_axi_wr.sv
// Testbench for the AXI-Stream to AXI4 write master
// Command table, stream source and AXI4 slave model around the DUT

`timescale 1ns/1ns
`default_nettype none

module tb_axis_axi_wr
   import axis_axi_wr_pkg::*;
();

   localparam int          CLK_PERIOD  = 40;
   localparam int          DRIVE_DLY   = 2;
   localparam logic [31:0] SEED        = 32'hbc280d55;
   localparam int          N_CMDS      = 8;
   localparam int          MARGIN      = 64;
   localparam int          LEN_W       = 16;
   localparam int          MAX_BEATS   = 16;
   localparam int          CMD_DEPTH   = 4;
   localparam logic [1:0]  RESP_SLVERR = 2'b10;

   logic                    clk;
   logic                    arst_n;
   logic                    start_valid;
   logic                    start_ready;
   logic [AXI_ADDR_W-1:0]   start_addr;
   logic [LEN_W-1:0]        start_len;
   logic                    axis_valid;
   logic                    axis_ready;
   logic [AXI_DATA_W-1:0]   axis_data;
   logic                    awvalid;
   logic                    awready;
   logic [AXI_ADDR_W-1:0]   awaddr;
   logic [AXI_LEN_W-1:0]    awlen;
   logic                    wvalid;
   logic                    wready;
   logic [AXI_DATA_W-1:0]   wdata;
   logic [AXI_DATA_W/8-1:0] wstrb;
   logic                    wlast;
   logic                    bvalid;
   logic                    bready;
   logic [AXI_RESP_W-1:0]   bresp;
   logic                    busy;
   logic                    done;
   logic                    err;

   // Command table
   logic [AXI_ADDR_W-1:0] tbl_addr [N_CMDS];
   int                    tbl_len [N_CMDS];
   logic [AXI_RESP_W-1:0] tbl_resp [N_CMDS];
   logic                  tbl_stall [N_CMDS];
   int                    tbl_bursts [N_CMDS];
   logic                  tbl_err [N_CMDS];

   logic                  stall_en;
   logic [AXI_RESP_W-1:0] resp_code;
   int                    exp_bursts;
   logic                  exp_err;
   int                    errors;
   int                    cmds;
   int                    total_beats = 0;
   int                    limit_cycles = 0;
   int                    cycles = 0;

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic set_entry(input int idx, input logic [31:0] addr, input int len,
                            input logic [1:0] resp, input logic stall, input int bursts,
                            input logic exp_e);
      tbl_addr[idx]   = addr;
      tbl_len[idx]    = len;
      tbl_resp[idx]   = resp;
      tbl_stall[idx]  = stall;
      tbl_bursts[idx] = bursts;
      tbl_err[idx]    = exp_e;
      total_beats     = total_beats + len;
   endtask

   task automatic load_table();
      // Index, address, words, B code, stalls, expected bursts, expected error
      set_entry(0, 32'h0000_1000,  8, RESP_OKAY,   1'b0, 1, 1'b0);
      set_entry(1, 32'h0000_2ff4, 10, RESP_OKAY,   1'b0, 2, 1'b0);
      set_entry(2, 32'h0000_4000, 40, RESP_OKAY,   1'b0, 3, 1'b0);
      set_entry(3, 32'h0000_5fc0, 64, RESP_OKAY,   1'b1, 4, 1'b0);
      set_entry(4, 32'h0000_7000,  8, RESP_SLVERR, 1'b0, 1, 1'b1);
      set_entry(5, 32'h0000_8000,  0, RESP_OKAY,   1'b0, 0, 1'b0);
      set_entry(6, 32'h0000_9010,  8, RESP_OKAY,   1'b1, 1, 1'b0);
      set_entry(7, 32'h0000_aff8, 37, RESP_OKAY,   1'b1, 4, 1'b0);
   endtask

   // Entered at a rising edge, returns at the edge that shows done
   task automatic run_command(input int idx);
      #DRIVE_DLY;
      start_valid = 1'b1;
      start_addr  = tbl_addr[idx];
      start_len   = LEN_W'(tbl_len[idx]);
      resp_code   = tbl_resp[idx];
      stall_en    = tbl_stall[idx];
      exp_bursts  = tbl_bursts[idx];
      exp_err     = tbl_err[idx];
      do begin
         @(posedge clk);
      end while (!start_ready);
      #DRIVE_DLY;
      start_valid = 1'b0;
      do begin
         @(posedge clk);
      end while (!done);
   endtask

   initial begin : clock_gen
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   initial begin : main_seq
      arst_n      = 1'b0;
      start_valid = 1'b0;
      start_addr  = '0;
      start_len   = '0;
      stall_en    = 1'b0;
      resp_code   = RESP_OKAY;
      exp_bursts  = 0;
      exp_err     = 1'b0;
      load_table();
      limit_cycles = 2 * total_beats + MARGIN * N_CMDS;
      repeat (5) @(posedge clk);
      #DRIVE_DLY;
      arst_n = 1'b1;
      @(posedge clk);
      for (int i = 0; i < N_CMDS; i++) begin
         run_command(i);
      end
      repeat (4) @(posedge clk);
      $display("%0d of %0d commands finished, %0d errors", cmds, N_CMDS, errors);
      if (errors == 0 && cmds == N_CMDS) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Stream words follow the LCG, with random gaps in stall mode
   initial begin : stream_source
      logic [31:0] gap_rng;
      logic        fire;
      gap_rng    = SEED;
      axis_valid = 1'b0;
      axis_data  = lcg_next(SEED);
      forever begin
         @(posedge clk);
         fire    = axis_valid && axis_ready;
         gap_rng = lcg_next(gap_rng);
         #DRIVE_DLY;
         if (fire) begin
            axis_data = lcg_next(axis_data);
         end
         // A word on offer stays until taken
         if (fire || !axis_valid) begin
            axis_valid = !(stall_en && gap_rng[31:30] == 2'b00);
         end
      end
   end

   initial begin : slave_model
      logic [31:0] bp_rng;
      int          aw_seen;
      int          wlast_seen;
      int          b_sent;
      bp_rng     = ~SEED;
      aw_seen    = 0;
      wlast_seen = 0;
      b_sent     = 0;
      awready    = 1'b0;
      wready     = 1'b0;
      bvalid     = 1'b0;
      bresp      = RESP_OKAY;
      forever begin
         @(posedge clk);
         if (awvalid && awready) begin
            aw_seen++;
         end
         if (wvalid && wready && wlast) begin
            wlast_seen++;
         end
         if (bvalid && bready) begin
            b_sent++;
         end
         bp_rng = lcg_next(bp_rng);
         #DRIVE_DLY;
         awready = !(stall_en && bp_rng[31:30] == 2'b00);
         wready  = !(stall_en && bp_rng[29:28] == 2'b00);
         // Answer a burst once its address and last beat are both in
         bvalid  = ((aw_seen < wlast_seen) ? aw_seen : wlast_seen) > b_sent;
         bresp   = resp_code;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit_cycles) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   axis_axi_wr_top #(
      .LEN_W    (LEN_W),
      .MAX_BEATS(MAX_BEATS),
      .CMD_DEPTH(CMD_DEPTH)
   ) u_dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .start_valid_i(start_valid),
      .start_ready_o(start_ready),
      .start_addr_i (start_addr),
      .start_len_i  (start_len),
      .axis_valid_i (axis_valid),
      .axis_ready_o (axis_ready),
      .axis_data_i  (axis_data),
      .awvalid_o    (awvalid),
      .awready_i    (awready),
      .awaddr_o     (awaddr),
      .awlen_o      (awlen),
      .wvalid_o     (wvalid),
      .wready_i     (wready),
      .wdata_o      (wdata),
      .wstrb_o      (wstrb),
      .wlast_o      (wlast),
      .bvalid_i     (bvalid),
      .bready_o     (bready),
      .bresp_i      (bresp),
      .busy_o       (busy),
      .done_o       (done),
      .err_o        (err)
   );

   tb_axi_wr_checker #(
      .LEN_W    (LEN_W),
      .MAX_BEATS(MAX_BEATS),
      .SEED     (SEED)
   ) u_checker (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .start_valid_i(start_valid),
      .start_ready_i(start_ready),
      .start_addr_i (start_addr),
      .start_len_i  (start_len),
      .axis_valid_i (axis_valid),
      .axis_ready_i (axis_ready),
      .awvalid_i    (awvalid),
      .awready_i    (awready),
      .awaddr_i     (awaddr),
      .awlen_i      (awlen),
      .wvalid_i     (wvalid),
      .wready_i     (wready),
      .wdata_i      (wdata),
      .wstrb_i      (wstrb),
      .wlast_i      (wlast),
      .bvalid_i     (bvalid),
      .bready_i     (bready),
      .bresp_i      (bresp),
      .busy_i       (busy),
      .done_i       (done),
      .err_i        (err),
      .exp_bursts_i (exp_bursts),
      .exp_err_i    (exp_err),
      .errors_o     (errors),
      .cmds_o       (cmds)
   );

endmodule

`default_nettype wire

// File: test/tb_axi_wr_checker.sv
// Scoreboard for the AXI-Stream to AXI4 write master
// Predicts bursts and stream data and compares them with the DUT ports

`timescale 1ns/1ns
`default_nettype none

module tb_axi_wr_checker
   import axis_axi_wr_pkg::*;
#(
   parameter int          LEN_W     = 16,
   parameter int          MAX_BEATS = 16,
   parameter logic [31:0] SEED      = 32'hbc280d55
) (
   input  wire                     clk_i,
   input  wire                     arst_n_i,
   input  wire                     start_valid_i,
   input  wire                     start_ready_i,
   input  wire  [AXI_ADDR_W-1:0]   start_addr_i,
   input  wire  [LEN_W-1:0]        start_len_i,
   input  wire                     axis_valid_i,
   input  wire                     axis_ready_i,
   input  wire                     awvalid_i,
   input  wire                     awready_i,
   input  wire  [AXI_ADDR_W-1:0]   awaddr_i,
   input  wire  [AXI_LEN_W-1:0]    awlen_i,
   input  wire                     wvalid_i,
   input  wire                     wready_i,
   input  wire  [AXI_DATA_W-1:0]   wdata_i,
   input  wire  [AXI_DATA_W/8-1:0] wstrb_i,
   input  wire                     wlast_i,
   input  wire                     bvalid_i,
   input  wire                     bready_i,
   input  wire  [AXI_RESP_W-1:0]   bresp_i,
   input  wire                     busy_i,
   input  wire                     done_i,
   input  wire                     err_i,
   input  int                      exp_bursts_i,
   input  wire                     exp_err_i,
   output int                      errors_o,
   output int                      cmds_o
);

   logic [AXI_ADDR_W-1:0] aw_addr_q [$];
   logic [AXI_LEN_W-1:0]  aw_len_q [$];
   logic [AXI_LEN_W-1:0]  w_len_q [$];
   logic [31:0]           exp_word = SEED;
   int                    err_cnt = 0;
   int                    cmd_cnt = 0;
   int                    err_base = 0;
   int                    beat_cnt = 0;
   int                    b_left = 0;
   int                    aw_cnt = 0;
   int                    since_start = 0;
   int                    stream_left = 0;
   logic                  cmd_active = 1'b0;
   logic                  first_aw = 1'b0;
   logic                  err_seen = 1'b0;
   logic                  done_q = 1'b0;
   logic                  done_due = 1'b0;

   assign errors_o = err_cnt;
   assign cmds_o   = cmd_cnt;

   function automatic logic [31:0] lcg_next(input logic [31:0] x);
      return x * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic value_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      err_cnt++;
   endtask

   task automatic protocol_error(input string msg);
      $display("At %0t ns: %s", $time, msg);
      err_cnt++;
   endtask

   // Splitting rule: remaining words, MAX_BEATS, words left in the 4 KB page
   task automatic plan_bursts(input logic [AXI_ADDR_W-1:0] addr, input int len);
      logic [AXI_ADDR_W-1:0] a;
      int                    rem;
      int                    beats;
      int                    page;
      a      = {addr[AXI_ADDR_W-1:2], 2'b00};
      rem    = len;
      b_left = 0;
      while (rem > 0) begin
         page  = 1024 - int'(a[11:2]);
         beats = (rem < MAX_BEATS) ? rem : MAX_BEATS;
         if (page < beats) begin
            beats = page;
         end
         aw_addr_q.push_back(a);
         aw_len_q.push_back(AXI_LEN_W'(beats - 1));
         w_len_q.push_back(AXI_LEN_W'(beats - 1));
         a   = a + AXI_ADDR_W'(beats * 4);
         rem = rem - beats;
         b_left++;
      end
   endtask

   always @(posedge clk_i) begin
      if (!arst_n_i) begin
         if (awvalid_i || wvalid_i || done_i || busy_i || err_i) begin
            value_error("valid or status output high during reset");
         end
      end else begin
         since_start++;
         // Ready for a new command only once the running one is done
         if (cmd_active && !done_i && start_ready_i) begin
            value_error("start_ready_o high while a command was running");
         end
         // Done follows the final B response by one cycle
         if (done_due && !done_i) begin
            value_error("no done pulse the cycle after the last B response");
         end
         done_due = 1'b0;
         if (start_valid_i && start_ready_i) begin
            plan_bursts(start_addr_i, int'(start_len_i));
            cmd_active  = 1'b1;
            first_aw    = start_len_i != '0;
            err_seen    = 1'b0;
            aw_cnt      = 0;
            stream_left = int'(start_len_i);
            since_start = 0;
            err_base    = err_cnt;
         end
         if (axis_valid_i && axis_ready_i) begin
            if (stream_left == 0) begin
               protocol_error("stream word taken beyond the command length");
            end else begin
               stream_left--;
            end
         end
         // Planner register plus AW slice
         if (first_aw && awvalid_i) begin
            if (since_start != 2) begin
               value_error($sformatf("first awvalid %0d cycles after start, expected 2",
                                     since_start));
            end
            first_aw = 1'b0;
         end
         if (awvalid_i && awready_i) begin
            aw_cnt++;
            if (aw_addr_q.size() == 0) begin
               protocol_error("AW burst issued that no command asked for");
            end else begin
               if (awaddr_i !== aw_addr_q[0] || awlen_i !== aw_len_q[0]) begin
                  value_error($sformatf("AW addr %h len %0d, expected addr %h len %0d",
                                        awaddr_i, awlen_i, aw_addr_q[0], aw_len_q[0]));
               end
               void'(aw_addr_q.pop_front());
               void'(aw_len_q.pop_front());
            end
         end
         if (wvalid_i && wready_i) begin
            exp_word = lcg_next(exp_word);
            if (wdata_i !== exp_word) begin
               value_error($sformatf("wdata %h, expected %h", wdata_i, exp_word));
            end
            if (wstrb_i !== '1) begin
               value_error($sformatf("wstrb %b, expected all ones", wstrb_i));
            end
            if (w_len_q.size() == 0) begin
               protocol_error("W beat sent while no burst was planned");
            end else begin
               if (wlast_i !== (beat_cnt == int'(w_len_q[0]))) begin
                  value_error($sformatf("wlast %0b on beat %0d of a %0d-beat burst",
                                        wlast_i, beat_cnt + 1, int'(w_len_q[0]) + 1));
               end
               if (beat_cnt == int'(w_len_q[0])) begin
                  void'(w_len_q.pop_front());
                  beat_cnt = 0;
               end else begin
                  beat_cnt++;
               end
            end
         end
         if (bready_i !== 1'b1) begin
            value_error("bready_o low, expected it held high");
         end
         if (bvalid_i && bready_i) begin
            if (b_left == 0) begin
               protocol_error("B response arrived with no burst outstanding");
            end else begin
               b_left--;
               // All bursts answered, done is due next cycle
               if (b_left == 0) begin
                  done_due = 1'b1;
               end
            end
            if (bresp_i != RESP_OKAY) begin
               err_seen = 1'b1;
            end
         end
         if (done_i) begin
            if (done_q) begin
               protocol_error("done_o stayed high for more than one cycle");
            end else if (!cmd_active) begin
               protocol_error("done pulse without a running command");
            end else begin
               if (aw_addr_q.size() != 0 || w_len_q.size() != 0 || b_left != 0 ||
                   stream_left != 0) begin
                  protocol_error("command finished with bursts, words or responses pending");
               end
               if (aw_cnt != exp_bursts_i) begin
                  value_error($sformatf("%0d bursts, expected %0d", aw_cnt, exp_bursts_i));
               end
               if (err_i !== err_seen || err_i !== exp_err_i) begin
                  value_error($sformatf("err_o %0b at done, expected %0b", err_i, exp_err_i));
               end
               if (busy_i) begin
                  value_error("busy_o still high at the done pulse");
               end
               $display("Command %0d: %0d bursts, err %0b, %s", cmd_cnt, aw_cnt, err_i,
                        (err_cnt == err_base) ? "ok" : "mismatch");
               cmd_cnt++;
               cmd_active = 1'b0;
            end
         end
         done_q = done_i;
      end
   end

endmodule

`default_nettype wire

// File: logic/axis_axi_wr_top.sv
// AXI-Stream to AXI4 write master top level
// Planner, W packer, response tracker and AW slice behind plain ports

`timescale 1ns/1ns
`default_nettype none

module axis_axi_wr_top
   import axis_axi_wr_pkg::*;
#(
   parameter int LEN_W     = 16,
   parameter int MAX_BEATS = 16,
   parameter int CMD_DEPTH = 4
) (
   input  wire                     clk_i,
   input  wire                     arst_n_i,
   // Command
   input  wire                     start_valid_i,
   output logic                    start_ready_o,
   input  wire  [AXI_ADDR_W-1:0]   start_addr_i,
   input  wire  [LEN_W-1:0]        start_len_i,
   // Stream in
   input  wire                     axis_valid_i,
   output logic                    axis_ready_o,
   input  wire  [AXI_DATA_W-1:0]   axis_data_i,
   // AXI4 write address
   output logic                    awvalid_o,
   input  wire                     awready_i,
   output logic [AXI_ADDR_W-1:0]   awaddr_o,
   output logic [AXI_LEN_W-1:0]    awlen_o,
   // AXI4 write data
   output logic                    wvalid_o,
   input  wire                     wready_i,
   output logic [AXI_DATA_W-1:0]   wdata_o,
   output logic [AXI_DATA_W/8-1:0] wstrb_o,
   output logic                    wlast_o,
   // AXI4 write response
   input  wire                     bvalid_i,
   output logic                    bready_o,
   input  wire  [AXI_RESP_W-1:0]   bresp_i,
   // Status
   output logic                    busy_o,
   output logic                    done_o,
   output logic                    err_o
);

   logic        aw_valid;
   logic        aw_ready;
   aw_payload_t aw_data;
   aw_payload_t aw_out;
   w_payload_t  w_out;

   burst_cmd_if u_cmd_if ();

   aw_burst_planner #(
      .LEN_W    (LEN_W),
      .MAX_BEATS(MAX_BEATS)
   ) u_planner (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .start_valid_i(start_valid_i),
      .start_ready_o(start_ready_o),
      .start_addr_i (start_addr_i),
      .start_len_i  (start_len_i),
      .busy_i       (busy_o),
      .aw_valid_o   (aw_valid),
      .aw_ready_i   (aw_ready),
      .aw_data_o    (aw_data),
      .cmd_o        (u_cmd_if.planner)
   );

   axi_reg_slice #(
      .T(aw_payload_t)
   ) u_aw_slice (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .in_valid_i (aw_valid),
      .in_ready_o (aw_ready),
      .in_data_i  (aw_data),
      .out_valid_o(awvalid_o),
      .out_ready_i(awready_i),
      .out_data_o (aw_out)
   );

   w_beat_packer #(
      .CMD_DEPTH(CMD_DEPTH)
   ) u_packer (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .cmd_i       (u_cmd_if.packer),
      .axis_valid_i(axis_valid_i),
      .axis_ready_o(axis_ready_o),
      .axis_data_i (axis_data_i),
      .w_valid_o   (wvalid_o),
      .w_ready_i   (wready_i),
      .w_data_o    (w_out)
   );

   wr_resp_tracker #(
      .LEN_W(LEN_W)
   ) u_tracker (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .start_fire_i(start_valid_i && start_ready_o),
      .zero_len_i  (start_len_i == '0),
      .cmd_i       (u_cmd_if.monitor),
      .bvalid_i    (bvalid_i),
      .bresp_i     (bresp_i),
      .bready_o    (bready_o),
      .busy_o      (busy_o),
      .done_o      (done_o),
      .err_o       (err_o)
   );

   assign awaddr_o = aw_out.addr;
   assign awlen_o  = aw_out.len;
   assign wdata_o  = w_out.data;
   assign wlast_o  = w_out.last;
   // Full-word writes only
   assign wstrb_o  = '1;

endmodule

`default_nettype wire

// File: logic/wr_resp_tracker.sv
// Write response tracker
// Counts issued bursts against B responses and flags done and error

`timescale 1ns/1ns
`default_nettype none

module wr_resp_tracker
   import axis_axi_wr_pkg::*;
#(
   parameter int LEN_W = 16
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,
   input  wire                   start_fire_i,
   input  wire                   zero_len_i,
   burst_cmd_if.monitor          cmd_i,
   input  wire                   bvalid_i,
   input  wire  [AXI_RESP_W-1:0] bresp_i,
   output logic                  bready_o,
   output logic                  busy_o,
   output logic                  done_o,
   output logic                  err_o
);

   // Outstanding bursts, never more than the words of one command
   logic [LEN_W:0] count_q;
   logic [LEN_W:0] count_nxt;
   logic           last_q;
   logic           last_nxt;
   logic           issue;
   logic           resp;

   assign bready_o = 1'b1;
   assign issue    = cmd_i.valid && cmd_i.ready;
   assign resp     = bvalid_i && bready_o;

   always_comb begin
      count_nxt = count_q;
      if (issue && !resp) begin
         count_nxt = count_q + 1'b1;
      end else if (resp && !issue) begin
         count_nxt = count_q - 1'b1;
      end
      last_nxt = last_q || (issue && cmd_i.last);
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
         last_q  <= 1'b0;
         busy_o  <= 1'b0;
         done_o  <= 1'b0;
         err_o   <= 1'b0;
      end else begin
         done_o  <= 1'b0;
         count_q <= count_nxt;
         if (start_fire_i) begin
            err_o  <= 1'b0;
            last_q <= 1'b0;
            if (zero_len_i) begin
               done_o <= 1'b1;
            end else begin
               busy_o <= 1'b1;
            end
         end else begin
            last_q <= last_nxt;
            if (resp && bresp_i != RESP_OKAY) begin
               err_o <= 1'b1;
            end
            // All bursts issued and answered
            if (busy_o && last_nxt && count_nxt == '0) begin
               done_o <= 1'b1;
               busy_o <= 1'b0;
               last_q <= 1'b0;
            end
         end
      end
   end

   // Every B response belongs to a burst already issued
   a_no_stray_resp : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      resp |-> count_q != '0
   );

endmodule

`default_nettype wire

// File: logic/w_beat_packer.sv
// W beat packer
// Queues burst lengths and forwards stream words as W beats with wlast

`timescale 1ns/1ns
`default_nettype none

module w_beat_packer
   import axis_axi_wr_pkg::*;
#(
   parameter int CMD_DEPTH = 4
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,
   burst_cmd_if.packer           cmd_i,
   input  wire                   axis_valid_i,
   output logic                  axis_ready_o,
   input  wire  [AXI_DATA_W-1:0] axis_data_i,
   output logic                  w_valid_o,
   input  wire                   w_ready_i,
   output w_payload_t            w_data_o
);

   localparam int PW   = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int CNTW = $clog2(CMD_DEPTH + 1);

   logic [AXI_LEN_W-1:0] len_mem [CMD_DEPTH];
   logic [PW-1:0]        wr_ptr_q;
   logic [PW-1:0]        rd_ptr_q;
   logic [CNTW-1:0]      used_q;
   logic [AXI_LEN_W-1:0] beat_q;

   logic       push;
   logic       pop;
   logic       empty;
   logic       slice_ready;
   logic       beat_fire;
   w_payload_t beat;

   assign empty       = used_q == '0;
   assign cmd_i.ready = used_q != CNTW'(CMD_DEPTH);
   assign push        = cmd_i.valid && cmd_i.ready;

   // Words pass only while a burst is queued
   assign axis_ready_o = slice_ready && !empty;
   assign beat_fire    = axis_valid_i && axis_ready_o;

   assign beat.data = axis_data_i;
   assign beat.last = beat_q == len_mem[rd_ptr_q];
   assign pop       = beat_fire && beat.last;

   always_ff @(posedge clk_i) begin
      if (push) begin
         len_mem[wr_ptr_q] <= cmd_i.len;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         used_q   <= '0;
         beat_q   <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PW'(CMD_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PW'(CMD_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push && !pop) begin
            used_q <= used_q + 1'b1;
         end else if (pop && !push) begin
            used_q <= used_q - 1'b1;
         end
         // Beat counter restarts at each burst
         if (pop) begin
            beat_q <= '0;
         end else if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
         end
      end
   end

   axi_reg_slice #(
      .T(w_payload_t)
   ) u_w_slice (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .in_valid_i (axis_valid_i && !empty),
      .in_ready_o (slice_ready),
      .in_data_i  (beat),
      .out_valid_o(w_valid_o),
      .out_ready_i(w_ready_i),
      .out_data_o (w_data_o)
   );

endmodule

`default_nettype wire

// File: logic/aw_burst_planner.sv
// Burst planner for the AXI4 write master
// Splits a command at 4 KB boundaries and at MAX_BEATS, one burst per cycle

`timescale 1ns/1ns
`default_nettype none

module aw_burst_planner
   import axis_axi_wr_pkg::*;
#(
   parameter int LEN_W     = 16,
   parameter int MAX_BEATS = 16
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,
   input  wire                   start_valid_i,
   output logic                  start_ready_o,
   input  wire  [AXI_ADDR_W-1:0] start_addr_i,
   input  wire  [LEN_W-1:0]      start_len_i,
   input  wire                   busy_i,
   output logic                  aw_valid_o,
   input  wire                   aw_ready_i,
   output aw_payload_t           aw_data_o,
   burst_cmd_if.planner          cmd_o
);

   // Wide enough for the remaining length and the 1024-word page
   localparam int CW = (LEN_W > 11) ? LEN_W : 11;

   logic                  active_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]      rem_q;

   logic [CW-1:0]         rem_words;
   logic [CW-1:0]         page_words;
   logic [CW-1:0]         max_words;
   logic [CW-1:0]         beats;
   logic                  last_burst;
   logic                  start_fire;
   logic                  burst_fire;
   logic [AXI_ADDR_W-1:0] end_addr;

   assign start_ready_o = !busy_i && !active_q;
   assign start_fire    = start_valid_i && start_ready_o;

   // Words left before the next 4 KB boundary
   assign rem_words  = CW'(rem_q);
   assign page_words = CW'(11'd1024 - {1'b0, addr_q[11:2]});
   assign max_words  = CW'(MAX_BEATS);

   always_comb begin
      beats = rem_words;
      if (max_words < beats) begin
         beats = max_words;
      end
      if (page_words < beats) begin
         beats = page_words;
      end
   end

   assign last_burst = rem_words == beats;

   // Each side is offered the burst only while the other can take it
   assign aw_valid_o    = active_q && cmd_o.ready;
   assign cmd_o.valid   = active_q && aw_ready_i;
   assign burst_fire    = aw_valid_o && aw_ready_i;

   assign aw_data_o.addr = addr_q;
   assign aw_data_o.len  = AXI_LEN_W'(beats - 1'b1);
   assign cmd_o.len      = AXI_LEN_W'(beats - 1'b1);
   assign cmd_o.last     = last_burst;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         active_q <= 1'b0;
      end else if (start_fire) begin
         // Zero-length commands issue no bursts
         active_q <= start_len_i != '0;
      end else if (burst_fire && last_burst) begin
         active_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_fire) begin
         // Word aligned only
         addr_q <= {start_addr_i[AXI_ADDR_W-1:2], 2'b00};
         rem_q  <= start_len_i;
      end else if (burst_fire) begin
         addr_q <= addr_q + (AXI_ADDR_W'(beats) << 2);
         rem_q  <= rem_q - LEN_W'(beats);
      end
   end

   // Byte address of the final beat of the burst on offer
   assign end_addr = aw_data_o.addr + (AXI_ADDR_W'(aw_data_o.len) << 2);

   // Issued burst starts and ends in the same 4 KB page
   a_no_4k_cross : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      burst_fire |-> end_addr[AXI_ADDR_W-1:12] == aw_data_o.addr[AXI_ADDR_W-1:12]
   );

endmodule

`default_nettype wire

// File: logic/axi_reg_slice.sv
// Full-throughput register slice for a valid/ready channel
// Output register plus one skid entry, input ready comes from a flop

`timescale 1ns/1ns
`default_nettype none

module axi_reg_slice #(
   parameter type T = logic [31:0]
) (
   input  wire  clk_i,
   input  wire  arst_n_i,
   input  wire  in_valid_i,
   output logic in_ready_o,
   input  T     in_data_i,
   output logic out_valid_o,
   input  wire  out_ready_i,
   output T     out_data_o
);

   logic out_valid_q;
   logic skid_valid_q;
   logic out_load;
   T     out_data_q;
   T     skid_data_q;

   // Output register is free when empty or being drained
   assign out_load    = out_ready_i || !out_valid_q;
   assign in_ready_o  = !skid_valid_q;
   assign out_valid_o = out_valid_q;
   assign out_data_o  = out_data_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_valid_q  <= 1'b0;
         skid_valid_q <= 1'b0;
      end else if (out_load) begin
         out_valid_q  <= skid_valid_q || in_valid_i;
         skid_valid_q <= 1'b0;
      end else if (in_valid_i && !skid_valid_q) begin
         // Output stalled, park the incoming beat
         skid_valid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (out_load) begin
         out_data_q <= skid_valid_q ? skid_data_q : in_data_i;
      end
      if (!out_load && !skid_valid_q) begin
         skid_data_q <= in_data_i;
      end
   end

   // Stalled output keeps its beat
   a_hold_stalled : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
   );

endmodule

`default_nettype wire

// File: logic/burst_cmd_if.sv
// Burst command link from the planner to the W packer
// The response tracker watches it to count issued bursts

`timescale 1ns/1ns
`default_nettype none

interface burst_cmd_if
   import axis_axi_wr_pkg::*;
();

   logic                 valid;
   logic                 ready;
   // awlen value of the burst
   logic [AXI_LEN_W-1:0] len;
   // Final burst of the command
   logic                 last;

   modport planner (output valid, output len, output last, input ready);

   modport packer (input valid, input len, input last, output ready);

   modport monitor (input valid, input ready, input len, input last);

endinterface

`default_nettype wire

// File: logic/axis_axi_wr_pkg.sv
// AXI-Stream to AXI4 write master shared definitions
// Bus widths, channel payload structs and the B response code

`default_nettype none

package axis_axi_wr_pkg;

   // AXI4 bus widths
   localparam int AXI_ADDR_W = 32;
   // Burst size is fixed at 4 bytes, so the data bus is one word wide
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;
   localparam int AXI_RESP_W = 2;

   // Write response codes
   localparam logic [AXI_RESP_W-1:0] RESP_OKAY = 2'b00;

   // AW channel payload
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      // Beats minus one
      logic [AXI_LEN_W-1:0]  len;
   } aw_payload_t;

   // W channel payload
   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic                  last;
   } w_payload_t;

endpackage

`default_nettype wire
